// ==== sources.f ====
+incdir+verilog
verilog/rv_pkg.sv
verilog/hazard_if.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/hazard_unit.sv
verilog/rv32i_pipeline.sv
tb/tb_rv32i.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_rv32i -o tb_rv32i
./obj_dir/tb_rv32i | tee sim.log

if grep -q "PASS: all tests" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== tb/tb_rv32i.sv ====
`include "rv_params.svh"

module tb_rv32i;

  localparam int PROG_MAX = 64;

  logic        clk;
  logic        reset;
  logic [31:0] i_inst;
  logic [31:0] i_mem_rdata;
  logic [31:0] o_pc;
  logic        o_mem_write;
  logic [31:0] o_mem_addr;
  logic [31:0] o_mem_wdata;

  logic [31:0] prog [0:PROG_MAX-1];
  int          plen;
  logic [31:0] dmem [0:255];   // Data memory seen by the DUT
  logic [31:0] mdmem [0:255];  // Reference model copy
  logic [31:0] mregs [0:31];
  logic [31:0] exp_pc[$];
  logic [31:0] exp_addr[$];
  logic [31:0] exp_data[$];
  logic [31:0] rng_state = 32'h3a0f6e53;
  int          errors;
  int          tests_run;
  int          tests_failed;

  rv32i_pipeline rv32i_pipeline_inst (
    .clk         (clk),
    .reset       (reset),
    .i_inst      (i_inst),
    .i_mem_rdata (i_mem_rdata),
    .o_pc        (o_pc),
    .o_mem_write (o_mem_write),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Instruction encoders
  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OP_R};
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, `FUNCT3_W, imm[4:0], `OP_STORE};
  endfunction

  function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, `OP_LUI};
  endfunction

  // Word aligned offset inside the 1 KiB data memory
  function automatic logic [11:0] word_off(input logic [31:0] r);
    return {2'b00, r[7:0], 2'b00};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // One of the twelve ALU instructions, k selects which
  function automatic logic [31:0] arith(input int k, input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [31:0] r);
    case (k)
      0:       return rtype(7'h00, rs2, rs1, 3'b000, rd);
      1:       return rtype(7'h20, rs2, rs1, 3'b000, rd);
      2:       return rtype(7'h00, rs2, rs1, 3'b111, rd);
      3:       return rtype(7'h00, rs2, rs1, 3'b110, rd);
      4:       return rtype(7'h00, rs2, rs1, 3'b100, rd);
      5:       return rtype(7'h00, rs2, rs1, 3'b001, rd);
      6:       return itype(r[11:0], rs1, 3'b000, rd, `OP_I_ARITH);
      7:       return itype(r[11:0], rs1, 3'b111, rd, `OP_I_ARITH);
      8:       return itype(r[11:0], rs1, 3'b110, rd, `OP_I_ARITH);
      9:       return itype(r[11:0], rs1, 3'b100, rd, `OP_I_ARITH);
      10:      return itype({7'b0, r[4:0]}, rs1, 3'b001, rd, `OP_I_ARITH);
      default: return utype(r[31:12], rd);
    endcase
  endfunction

  function automatic logic reads_reg(input logic [31:0] w, input logic [4:0] r);
    logic [6:0] op;
    op = w[6:0];
    if (op == `OP_R || op == `OP_STORE)
      return (w[19:15] == r) || (w[24:20] == r);
    if (op == `OP_I_ARITH || op == `OP_LOAD)
      return w[19:15] == r;
    return 1'b0;
  endfunction

  // Load at index i whose result the next instruction needs
  function automatic logic load_use(input int i);
    if (i + 1 >= plen || prog[i][6:0] != `OP_LOAD || prog[i][11:7] == 5'd0)
      return 1'b0;
    return reads_reg(prog[i+1], prog[i][11:7]);
  endfunction

  function automatic logic [31:0] fetch(input logic [31:0] pc);
    if (pc[31:2] < 30'(plen))
      return prog[pc[31:2]];
    return 32'h0;  // Past the program, decodes as a bubble
  endfunction

  task automatic emit(input logic [31:0] w);
    prog[plen] = w;
    plen++;
  endtask

  // Executes the program in order and fills the expectation queues
  task automatic run_model();
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] ea;
    for (int j = 0; j < 32; j++)
      mregs[j] = 32'h0;
    for (int j = 0; j < 256; j++)
      mdmem[j] = dmem[j];
    exp_pc.delete();
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < plen; i++)
    begin
      w   = prog[i];
      a   = mregs[w[19:15]];
      b   = mregs[w[24:20]];
      res = 32'h0;
      case (w[6:0])
        `OP_R:
          case ({w[30], w[14:12]})
            4'b0000: res = a + b;
            4'b1000: res = a - b;
            4'b0111: res = a & b;
            4'b0110: res = a | b;
            4'b0100: res = a ^ b;
            default: res = a << b[4:0];
          endcase
        `OP_I_ARITH:
          case (w[14:12])
            3'b000:  res = a + sext12(w[31:20]);
            3'b111:  res = a & sext12(w[31:20]);
            3'b110:  res = a | sext12(w[31:20]);
            3'b100:  res = a ^ sext12(w[31:20]);
            default: res = a << w[24:20];
          endcase
        `OP_LOAD:
        begin
          ea  = a + sext12(w[31:20]);
          res = mdmem[ea[9:2]];
        end
        `OP_STORE:
        begin
          ea = a + sext12({w[31:25], w[11:7]});
          exp_addr.push_back(ea);
          exp_data.push_back(b);
          mdmem[ea[9:2]] = b;
        end
        default: res = {w[31:12], 12'h000};  // lui
      endcase
      if (w[6:0] != `OP_STORE && w[11:7] != 5'd0)
        mregs[w[11:7]] = res;
    end
    // Fetch address repeats once where a load-use pair stalls decode
    for (int j = 0; j <= plen + 4; j++)
    begin
      exp_pc.push_back(`RESET_PC + 32'(4 * j));
      if (j >= 2 && load_use(j - 2))
        exp_pc.push_back(`RESET_PC + 32'(4 * j));
    end
  endtask

  // Checks one cycle at the falling edge, then updates the memories and drives inputs
  task automatic cycle_step();
    logic [31:0] want;
    logic [31:0] want_data;
    if (exp_pc.size() > 0)
    begin
      want = exp_pc.pop_front();
      assert (o_pc === want)
      else
      begin
        $display("[ERROR] %0t: o_pc %h, expected %h", $time, o_pc, want);
        errors++;
      end
    end
    if (o_mem_write === 1'b1)
    begin
      assert (exp_addr.size() > 0)
      else
      begin
        $display("Store to %h seen at %0t where none was expected", o_mem_addr, $time);
        errors++;
      end
      if (exp_addr.size() > 0)
      begin
        want      = exp_addr.pop_front();
        want_data = exp_data.pop_front();
        assert (o_mem_addr === want && o_mem_wdata === want_data)
        else
        begin
          $display("[ERROR] %0t: store %h to %h, expected %h to %h", $time,
                   o_mem_wdata, o_mem_addr, want_data, want);
          errors++;
        end
      end
      dmem[o_mem_addr[9:2]] = o_mem_wdata;
    end
    else
    begin
      assert (o_mem_write === 1'b0)
      else
      begin
        $display("Memory write strobe is unknown at %0t", $time);
        errors++;
      end
    end
    i_inst      = fetch(o_pc);
    i_mem_rdata = dmem[o_mem_addr[9:2]];
  endtask

  task automatic run_program(input string name);
    int cycles;
    int limit;
    int errs_at_start;
    errs_at_start = errors;
    limit         = plen + 5 + 40;
    cycles        = 0;
    for (int k = 0; k < 256; k++)
      dmem[k] = xorshift32();
    run_model();
    reset = 1'b1;
    repeat (10)
    begin
      @(negedge clk);
      assert (o_pc === `RESET_PC && o_mem_write === 1'b0)
      else
      begin
        $display("[ERROR] %0t: in reset o_pc %h o_mem_write %b", $time, o_pc, o_mem_write);
        errors++;
      end
    end
    reset = 1'b0;
    cycle_step();  // First cycle out of reset still fetches RESET_PC
    while (exp_pc.size() > 0 || exp_addr.size() > 0)
    begin
      @(negedge clk);
      cycle_step();
      cycles++;
      if (cycles > limit)
      begin
        $display("Test %s did not finish within %0d cycles", name, limit);
        $display("FAIL: see errors above");
        $finish;
      end
    end
    tests_run++;
    if (errors == errs_at_start)
      $display("Test %s passed", name);
    else
    begin
      tests_failed++;
      $display("Test %s failed", name);
    end
  endtask

  task automatic build_arith();
    logic [31:0] r;
    plen = 0;
    for (int k = 0; k < 12; k++)
    begin
      r = xorshift32();
      emit(itype(r[11:0], 5'd0, 3'b000, 5'd1, `OP_I_ARITH));
      r = xorshift32();
      emit(itype(r[11:0], 5'd0, 3'b000, 5'd2, `OP_I_ARITH));
      r = xorshift32();
      emit(arith(k, 5'd3, 5'd1, 5'd2, r));
      r = xorshift32();
      emit(stype(word_off(r), 5'd3, 5'd0));
    end
  endtask

  // Consumer d instructions behind its producer
  task automatic build_distance();
    logic [31:0] r;
    plen = 0;
    for (int d = 1; d <= 3; d++)
    begin
      r = xorshift32();
      emit(itype(r[11:0], 5'd0, 3'b000, 5'd5, `OP_I_ARITH));
      for (int f = 1; f < d; f++)
        emit(itype(12'd1, 5'd0, 3'b000, 5'd20, `OP_I_ARITH));
      emit(rtype(7'h00, 5'd5, 5'd5, 3'b000, 5'd6));
      emit(stype(word_off(r >> 12), 5'd6, 5'd0));
      r = xorshift32();
      emit(itype(r[11:0], 5'd0, 3'b000, 5'd7, `OP_I_ARITH));
      for (int f = 1; f < d; f++)
        emit(itype(12'd1, 5'd0, 3'b000, 5'd20, `OP_I_ARITH));
      emit(stype(word_off(r >> 12), 5'd7, 5'd0));
    end
  endtask

  task automatic build_load_use();
    logic [31:0] r;
    plen = 0;
    for (int n = 0; n < 3; n++)
    begin
      r = xorshift32();
      emit(itype(r[11:0], 5'd0, 3'b000, 5'd1, `OP_I_ARITH));
      emit(itype(word_off(r >> 12), 5'd0, `FUNCT3_W, 5'd2, `OP_LOAD));
      emit(rtype(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));   // Uses the load on rs1
      emit(stype(word_off(r >> 20), 5'd3, 5'd0));
      r = xorshift32();
      emit(itype(word_off(r), 5'd0, `FUNCT3_W, 5'd4, `OP_LOAD));
      emit(rtype(7'h00, 5'd4, 5'd1, 3'b000, 5'd3));   // And on rs2
      emit(stype(word_off(r >> 8), 5'd3, 5'd0));
      emit(itype(word_off(r >> 16), 5'd0, `FUNCT3_W, 5'd9, `OP_LOAD));
      emit(stype(word_off(r >> 24), 5'd9, 5'd0));
    end
  endtask

  task automatic build_x0();
    logic [31:0] r;
    plen = 0;
    r = xorshift32();
    emit(itype(r[11:0], 5'd0, 3'b000, 5'd1, `OP_I_ARITH));
    emit(itype(r[23:12], 5'd0, 3'b000, 5'd0, `OP_I_ARITH));
    emit(rtype(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
    emit(utype(r[31:12], 5'd0));
    emit(stype(word_off(r), 5'd0, 5'd0));
    emit(rtype(7'h00, 5'd1, 5'd0, 3'b000, 5'd8));
    emit(stype(word_off(r >> 8), 5'd8, 5'd0));
    emit(itype(word_off(r >> 16), 5'd0, `FUNCT3_W, 5'd0, `OP_LOAD));
    emit(rtype(7'h00, 5'd0, 5'd0, 3'b000, 5'd9));
    emit(stype(word_off(r >> 24), 5'd9, 5'd0));
  endtask

  initial
  begin
    reset        = 1'b1;
    i_inst       = 32'h0;
    i_mem_rdata  = 32'h0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    plen         = 0;
    run_program("reset");
    build_arith();
    run_program("arith");
    build_distance();
    run_program("forwarding");
    build_load_use();
    run_program("load_use");
    build_x0();
    run_program("x0_writes");
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== verilog/rv32i_pipeline.sv ====
`include "rv_params.svh"

module rv32i_pipeline import rv_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic [`XLEN-1:0] i_inst,
  input  logic [`XLEN-1:0] i_mem_rdata,
  output logic [`XLEN-1:0] o_pc,
  output logic             o_mem_write,
  output logic [`XLEN-1:0] o_mem_addr,
  output logic [`XLEN-1:0] o_mem_wdata
);

  logic [`XLEN-1:0]   pc;
  logic [`XLEN-1:0]   if_id_inst;

  ctrl_t              id_ex_ctrl;
  logic [`REG_AW-1:0] id_ex_rs1;
  logic [`REG_AW-1:0] id_ex_rs2;
  logic [`REG_AW-1:0] id_ex_rd;
  logic [`XLEN-1:0]   id_ex_rs1_data;
  logic [`XLEN-1:0]   id_ex_rs2_data;
  logic [`XLEN-1:0]   id_ex_imm;

  ctrl_t              ex_mem_ctrl;
  logic [`REG_AW-1:0] ex_mem_rd;
  logic [`XLEN-1:0]   ex_mem_alu;
  logic [`XLEN-1:0]   ex_mem_wdata;

  ctrl_t              mem_wb_ctrl;
  logic [`REG_AW-1:0] mem_wb_rd;
  logic [`XLEN-1:0]   mem_wb_alu;
  logic [`XLEN-1:0]   mem_wb_rdata;

  logic [6:0]         id_opcode;
  logic               id_use_rs1;
  logic               id_use_rs2;
  logic [`REG_AW-1:0] id_rs1;
  logic [`REG_AW-1:0] id_rs2;
  ctrl_t              id_ctrl;
  logic [`XLEN-1:0]   id_rs1_data;
  logic [`XLEN-1:0]   id_rs2_data;
  logic [`XLEN-1:0]   id_imm;

  logic [`XLEN-1:0]   ex_a_fwd;
  logic [`XLEN-1:0]   ex_b_fwd;
  logic [`XLEN-1:0]   alu_a;
  logic [`XLEN-1:0]   alu_b;
  logic [`XLEN-1:0]   alu_result;
  logic [`XLEN-1:0]   wb_data;

  hazard_if hz (.clk(clk));

  function automatic logic [`XLEN-1:0] fwd_pick(input fwd_sel_t sel,
                                                input logic [`XLEN-1:0] reg_val,
                                                input logic [`XLEN-1:0] mem_val,
                                                input logic [`XLEN-1:0] wb_val);
    case (sel)
      FWD_MEM: fwd_pick = mem_val;
      FWD_WB:  fwd_pick = wb_val;
      default: fwd_pick = reg_val;
    endcase
  endfunction

  // Fetch, held on a load-use stall
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pc         <= `RESET_PC;
      if_id_inst <= '0;
    end
    else if (!hz.stall)
    begin
      pc         <= pc + `XLEN'(4);
      if_id_inst <= i_inst;
    end
  end

  // Decode. Unused source fields are zeroed so they never match a producer
  assign id_opcode  = if_id_inst[6:0];
  assign id_use_rs1 = (id_opcode == `OP_R) || (id_opcode == `OP_I_ARITH) ||
                      (id_opcode == `OP_LOAD) || (id_opcode == `OP_STORE);
  assign id_use_rs2 = (id_opcode == `OP_R) || (id_opcode == `OP_STORE);
  assign id_rs1     = id_use_rs1 ? if_id_inst[19:15] : '0;
  assign id_rs2     = id_use_rs2 ? if_id_inst[24:20] : '0;

  // U for lui, S for stores, I otherwise
  always_comb
  begin
    if (id_opcode == `OP_LUI)
      id_imm = {if_id_inst[31:12], 12'b0};
    else if (id_opcode == `OP_STORE)
      id_imm = {{20{if_id_inst[31]}}, if_id_inst[31:25], if_id_inst[11:7]};
    else
      id_imm = {{20{if_id_inst[31]}}, if_id_inst[31:20]};
  end

  decoder decoder_inst (
    .i_opcode (id_opcode),
    .i_funct3 (if_id_inst[14:12]),
    .i_funct7 (if_id_inst[31:25]),
    .o_ctrl   (id_ctrl)
  );

  regfile regfile_inst (
    .clk        (clk),
    .i_we       (mem_wb_ctrl.regwrite),
    .i_rs1      (id_rs1),
    .i_rs2      (id_rs2),
    .i_rd       (mem_wb_rd),
    .i_rd_data  (wb_data),
    .o_rs1_data (id_rs1_data),
    .o_rs2_data (id_rs2_data)
  );

  assign hz.id_rs1       = id_rs1;
  assign hz.id_rs2       = id_rs2;
  assign hz.ex_rs1       = id_ex_rs1;
  assign hz.ex_rs2       = id_ex_rs2;
  assign hz.ex_rd        = id_ex_rd;
  assign hz.ex_memtoreg  = id_ex_ctrl.memtoreg;
  assign hz.mem_rd       = ex_mem_rd;
  assign hz.mem_regwrite = ex_mem_ctrl.regwrite;
  assign hz.wb_rd        = mem_wb_rd;
  assign hz.wb_regwrite  = mem_wb_ctrl.regwrite;

  hazard_unit hazard_unit_inst (.hz(hz.unit));

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      id_ex_ctrl     <= '0;
      id_ex_rs1      <= '0;
      id_ex_rs2      <= '0;
      id_ex_rd       <= '0;
      id_ex_rs1_data <= '0;
      id_ex_rs2_data <= '0;
      id_ex_imm      <= '0;
    end
    else
    begin
      id_ex_ctrl     <= hz.stall ? ctrl_t'('0) : id_ctrl;  // Bubble behind a load
      id_ex_rs1      <= id_rs1;
      id_ex_rs2      <= id_rs2;
      id_ex_rd       <= if_id_inst[11:7];
      id_ex_rs1_data <= hz.byp_rs1 ? wb_data : id_rs1_data;
      id_ex_rs2_data <= hz.byp_rs2 ? wb_data : id_rs2_data;
      id_ex_imm      <= id_imm;
    end
  end

  // Execute
  assign ex_a_fwd = fwd_pick(hz.fwd_a, id_ex_rs1_data, ex_mem_alu, wb_data);
  assign ex_b_fwd = fwd_pick(hz.fwd_b, id_ex_rs2_data, ex_mem_alu, wb_data);
  assign alu_a    = id_ex_ctrl.lui ? '0 : ex_a_fwd;
  assign alu_b    = (id_ex_ctrl.alusrc || id_ex_ctrl.lui) ? id_ex_imm : ex_b_fwd;

  alu alu_inst (
    .i_a      (alu_a),
    .i_b      (alu_b),
    .i_op     (id_ex_ctrl.alu_op),
    .o_result (alu_result)
  );

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ex_mem_ctrl  <= '0;
      ex_mem_rd    <= '0;
      ex_mem_alu   <= '0;
      ex_mem_wdata <= '0;
      mem_wb_ctrl  <= '0;
      mem_wb_rd    <= '0;
      mem_wb_alu   <= '0;
      mem_wb_rdata <= '0;
    end
    else
    begin
      ex_mem_ctrl  <= id_ex_ctrl;
      ex_mem_rd    <= id_ex_rd;
      ex_mem_alu   <= alu_result;
      ex_mem_wdata <= ex_b_fwd;       // Store data after forwarding
      mem_wb_ctrl  <= ex_mem_ctrl;
      mem_wb_rd    <= ex_mem_rd;
      mem_wb_alu   <= ex_mem_alu;
      mem_wb_rdata <= i_mem_rdata;    // Load data captured leaving MEM
    end
  end

  assign wb_data = mem_wb_ctrl.memtoreg ? mem_wb_rdata : mem_wb_alu;

  assign o_pc        = pc;
  assign o_mem_write = ex_mem_ctrl.memwrite;
  assign o_mem_addr  = ex_mem_alu;
  assign o_mem_wdata = ex_mem_wdata;

endmodule

// ==== verilog/hazard_unit.sv ====
`include "rv_params.svh"

module hazard_unit import rv_pkg::*;
(
  hazard_if.unit hz
);

  logic mem_a_hit;
  logic mem_b_hit;
  logic wb_a_hit;
  logic wb_b_hit;

  // Load in execute feeding the instruction in decode
  assign hz.stall = hz.ex_memtoreg && (hz.ex_rd != '0) &&
                    ((hz.ex_rd == hz.id_rs1) || (hz.ex_rd == hz.id_rs2));

  // Producers one and two stages ahead of execute
  assign mem_a_hit = hz.mem_regwrite && (hz.mem_rd != '0) && (hz.mem_rd == hz.ex_rs1);
  assign mem_b_hit = hz.mem_regwrite && (hz.mem_rd != '0) && (hz.mem_rd == hz.ex_rs2);
  assign wb_a_hit  = hz.wb_regwrite && (hz.wb_rd != '0) && (hz.wb_rd == hz.ex_rs1);
  assign wb_b_hit  = hz.wb_regwrite && (hz.wb_rd != '0) && (hz.wb_rd == hz.ex_rs2);

  // Younger result wins
  assign hz.fwd_a = mem_a_hit ? FWD_MEM : (wb_a_hit ? FWD_WB : FWD_REG);
  assign hz.fwd_b = mem_b_hit ? FWD_MEM : (wb_b_hit ? FWD_WB : FWD_REG);

  // Register written back this cycle while decode reads it
  assign hz.byp_rs1 = hz.wb_regwrite && (hz.wb_rd != '0) && (hz.wb_rd == hz.id_rs1);
  assign hz.byp_rs2 = hz.wb_regwrite && (hz.wb_rd != '0) && (hz.wb_rd == hz.id_rs2);

  // The bubble behind a load clears the stall
  a_stall_one_cycle: assert property (@(posedge hz.clk)
    hz.stall |=> !hz.stall)
    else $error("hazard_unit: stall longer than one cycle");

endmodule

// ==== verilog/alu.sv ====
`include "rv_params.svh"

module alu import rv_pkg::*;
(
  input  logic [`XLEN-1:0] i_a,
  input  logic [`XLEN-1:0] i_b,
  input  alu_op_t          i_op,
  output logic [`XLEN-1:0] o_result
);

  logic [4:0] shamt;

  assign shamt = i_b[4:0];  // Shift by low five bits only

  always_comb
  begin
    case (i_op)
      ALU_ADD: o_result = i_a + i_b;
      ALU_SUB: o_result = i_a - i_b;
      ALU_AND: o_result = i_a & i_b;
      ALU_OR:  o_result = i_a | i_b;
      ALU_XOR: o_result = i_a ^ i_b;
      ALU_SLL: o_result = i_a << shamt;
      default: o_result = '0;
    endcase
  end

endmodule

// ==== verilog/regfile.sv ====
`include "rv_params.svh"

module regfile
(
  input  logic               clk,
  input  logic               i_we,
  input  logic [`REG_AW-1:0] i_rs1,
  input  logic [`REG_AW-1:0] i_rs2,
  input  logic [`REG_AW-1:0] i_rd,
  input  logic [`XLEN-1:0]   i_rd_data,
  output logic [`XLEN-1:0]   o_rs1_data,
  output logic [`XLEN-1:0]   o_rs2_data
);

  logic [`XLEN-1:0] regs [1:31];  // x0 has no storage

  always_ff @(posedge clk)
  begin
    if (i_we && i_rd != '0)
      regs[i_rd] <= i_rd_data;
  end

  // Old value on a same-cycle write, the pipeline bypasses that case
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

  // Written register reads back its new value one cycle later
  a_write_read: assert property (@(posedge clk)
    (i_we && i_rd != '0) |=>
      ((i_rs1 != $past(i_rd) || o_rs1_data == $past(i_rd_data)) &&
       (i_rs2 != $past(i_rd) || o_rs2_data == $past(i_rd_data))))
    else $error("regfile: written register read back wrong");

endmodule

// ==== verilog/decoder.sv ====
`include "rv_params.svh"

module decoder import rv_pkg::*;
(
  input  logic [6:0] i_opcode,
  input  logic [2:0] i_funct3,
  input  logic [6:0] i_funct7,
  output ctrl_t      o_ctrl
);

  always_comb
  begin
    o_ctrl = '0;
    case (i_opcode)
      `OP_R:
      begin
        o_ctrl.regwrite = 1'b1;
        case ({i_funct7, i_funct3})
          10'b0000000_000: o_ctrl.alu_op = ALU_ADD;
          10'b0100000_000: o_ctrl.alu_op = ALU_SUB;
          10'b0000000_111: o_ctrl.alu_op = ALU_AND;
          10'b0000000_110: o_ctrl.alu_op = ALU_OR;
          10'b0000000_100: o_ctrl.alu_op = ALU_XOR;
          10'b0000000_001: o_ctrl.alu_op = ALU_SLL;
          default:         o_ctrl = '0;  // Not supported
        endcase
      end
      `OP_I_ARITH:
      begin
        o_ctrl.regwrite = 1'b1;
        o_ctrl.alusrc   = 1'b1;
        case (i_funct3)
          3'b000: o_ctrl.alu_op = ALU_ADD;
          3'b111: o_ctrl.alu_op = ALU_AND;
          3'b110: o_ctrl.alu_op = ALU_OR;
          3'b100: o_ctrl.alu_op = ALU_XOR;
          3'b001:
          begin
            // slli needs funct7 zero, the srai pattern is not kept
            if (i_funct7 == 7'b0000000)
              o_ctrl.alu_op = ALU_SLL;
            else
              o_ctrl = '0;
          end
          default: o_ctrl = '0;
        endcase
      end
      `OP_LOAD:
      begin
        if (i_funct3 == `FUNCT3_W)
        begin
          o_ctrl.regwrite = 1'b1;
          o_ctrl.alusrc   = 1'b1;
          o_ctrl.memtoreg = 1'b1;  // Address by add
        end
      end
      `OP_STORE:
      begin
        if (i_funct3 == `FUNCT3_W)
        begin
          o_ctrl.alusrc   = 1'b1;
          o_ctrl.memwrite = 1'b1;
        end
      end
      `OP_LUI:
      begin
        o_ctrl.lui      = 1'b1;  // Zero plus U immediate
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.regwrite = 1'b1;
      end
      default: o_ctrl = '0;
    endcase
  end

  // Any known opcode gives a clean control word, funct garbage included
  always_comb
  begin
    if (!$isunknown(i_opcode))
      a_ctrl_known: assert (!$isunknown(o_ctrl))
        else $error("decoder: control unknown for opcode %b", i_opcode);
  end

endmodule

// ==== verilog/hazard_if.sv ====
`include "rv_params.svh"

interface hazard_if import rv_pkg::*; (input logic clk);

  // Source indices, masked to zero when the field is not a register
  logic [`REG_AW-1:0] id_rs1;
  logic [`REG_AW-1:0] id_rs2;
  logic [`REG_AW-1:0] ex_rs1;
  logic [`REG_AW-1:0] ex_rs2;

  // Destinations further down
  logic [`REG_AW-1:0] ex_rd;
  logic               ex_memtoreg;
  logic [`REG_AW-1:0] mem_rd;
  logic               mem_regwrite;
  logic [`REG_AW-1:0] wb_rd;
  logic               wb_regwrite;

  // Results from the hazard unit
  logic     stall;
  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  logic     byp_rs1;
  logic     byp_rs2;

  modport pipe (
    output id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_memtoreg,
    output mem_rd, mem_regwrite, wb_rd, wb_regwrite,
    input  stall, fwd_a, fwd_b, byp_rs1, byp_rs2
  );

  modport unit (
    input  clk,
    input  id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_memtoreg,
    input  mem_rd, mem_regwrite, wb_rd, wb_regwrite,
    output stall, fwd_a, fwd_b, byp_rs1, byp_rs2
  );

endinterface

// ==== verilog/rv_pkg.sv ====
package rv_pkg;

  // ALU operations, ALU_ADD first so a zeroed control word adds
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5
  } alu_op_t;

  // Decoded control bits carried down the pipe, all zero is a bubble
  typedef struct packed {
    logic    lui;       // Operand a forced to zero, b is the U immediate
    logic    alusrc;    // Operand b from the immediate
    logic    memwrite;
    logic    memtoreg;  // Load
    logic    regwrite;
    alu_op_t alu_op;
  } ctrl_t;

  // Operand source for execute
  typedef enum logic [1:0] {
    FWD_REG = 2'd0,  // ID/EX register value
    FWD_MEM = 2'd1,  // EX/MEM ALU result
    FWD_WB  = 2'd2   // Write-back value
  } fwd_sel_t;

endpackage

// ==== verilog/rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Datapath and register index widths
`define XLEN   32
`define REG_AW 5

// RV32I opcodes, inst[6:0]
`define OP_R       7'b0110011
`define OP_I_ARITH 7'b0010011
`define OP_LOAD    7'b0000011
`define OP_STORE   7'b0100011
`define OP_LUI     7'b0110111

`define FUNCT3_W   3'b010   // lw / sw width field

// Fetch address after reset
`define RESET_PC   32'h0000_0000

`endif
